//--- core_pkg.sv
package core_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // Encoded like the low two bits of funct3 in the CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    // One exception as the pipeline reports it to the trap unit
    typedef struct packed {
        word_t cause;
        word_t pc;   // Address of the faulting instruction
        word_t tval; // Bad address or instruction bits, zero if none
    } trap_req_t;

endpackage

//--- csr_bus_arbiter.sv
`timescale 1ns/100ps

module csr_bus_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_bus_t trap_bus,
    input  csr_pkg::csr_bus_t instr_bus,
    output logic              trap_grant,
    output logic              instr_grant,
    output csr_pkg::csr_bus_t bus
);

    // Trap unit always wins, the instruction unit waits behind it
    assign trap_grant  = trap_bus.req;
    assign instr_grant = instr_bus.req && !trap_bus.req;

    always_comb begin
        if (trap_bus.req) begin
            bus = trap_bus;
        end else if (instr_bus.req) begin
            bus = instr_bus;
        end else begin
            bus = '0; // Idle bus, no write reaches the CSR file
        end
    end

    a_one_grant: assert property (
        @(posedge clk) disable iff (reset) !(trap_grant && instr_grant)
    );

endmodule

//--- csr_file.sv
`timescale 1ns/100ps

module csr_file #(
    parameter core_pkg::word_t HART_ID = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_bus_t bus,
    output core_pkg::word_t   rdata
);

    core_pkg::word_t mstatus;
    core_pkg::word_t mtvec;
    core_pkg::word_t mip;
    core_pkg::word_t mie;
    core_pkg::word_t mscratch;
    core_pkg::word_t mepc;
    core_pkg::word_t mcause;
    core_pkg::word_t mtval;
    core_pkg::word_t mcycle;
    core_pkg::word_t satp;

    logic wr_en;
    logic mcycle_wr;

    assign wr_en     = bus.req && bus.we;
    assign mcycle_wr = wr_en && (bus.addr == csr_pkg::CSR_MCYCLE); // Write address only

    always_comb begin
        case (bus.addr)
            csr_pkg::CSR_MSTATUS:  rdata = mstatus;
            csr_pkg::CSR_MTVEC:    rdata = mtvec;
            csr_pkg::CSR_MIP:      rdata = mip;
            csr_pkg::CSR_MIE:      rdata = mie;
            csr_pkg::CSR_MSCRATCH: rdata = mscratch;
            csr_pkg::CSR_MEPC:     rdata = mepc;
            csr_pkg::CSR_MCAUSE:   rdata = mcause;
            csr_pkg::CSR_MTVAL:    rdata = mtval;
            csr_pkg::CSR_MCYCLE:   rdata = mcycle;
            csr_pkg::CSR_SATP:     rdata = satp;
            csr_pkg::CSR_MHARTID:  rdata = HART_ID;
            default:               rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mip      <= '0;
            mie      <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            satp     <= '0;
        end else if (wr_en) begin
            case (bus.addr)
                csr_pkg::CSR_MSTATUS:  mstatus  <= bus.wdata & csr_pkg::MSTATUS_MASK;
                csr_pkg::CSR_MTVEC:    mtvec    <= bus.wdata & csr_pkg::MTVEC_MASK;
                csr_pkg::CSR_MIP:      mip      <= bus.wdata & csr_pkg::MIP_MASK;
                csr_pkg::CSR_MIE:      mie      <= bus.wdata;
                csr_pkg::CSR_MSCRATCH: mscratch <= bus.wdata;
                csr_pkg::CSR_MEPC:     mepc     <= bus.wdata;
                csr_pkg::CSR_MCAUSE:   mcause   <= bus.wdata;
                csr_pkg::CSR_MTVAL:    mtval    <= bus.wdata;
                csr_pkg::CSR_SATP:     satp     <= bus.wdata;
                default:               ; // Read-only and unknown addresses drop the write
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle <= '0;
        end else if (mcycle_wr) begin
            mcycle <= bus.wdata; // The written value replaces this cycle's increment
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    // Clients must only write while they hold the bus
    a_we_needs_req: assert property (
        @(posedge clk) disable iff (reset) bus.we |-> bus.req
    );

endmodule

//--- csr_instr_unit.sv
`timescale 1ns/100ps

module csr_instr_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_valid,
    input  core_pkg::csr_op_t  csr_op,
    input  csr_pkg::csr_addr_t csr_addr,
    input  core_pkg::word_t    csr_operand,
    output logic               csr_busy,
    output logic               csr_done,
    output core_pkg::word_t    csr_rdata,
    output csr_pkg::csr_bus_t  bus_req,
    input  logic               grant,
    input  core_pkg::word_t    bus_rdata
);

    logic               busy;
    core_pkg::csr_op_t  op_q;
    csr_pkg::csr_addr_t addr_q;
    core_pkg::word_t    operand_q;
    core_pkg::word_t    new_value;
    logic               write_en;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            csr_done <= 1'b0;
        end else begin
            csr_done <= busy && grant;
            if (csr_valid) begin
                busy <= 1'b1;
            end else if (grant) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csr_valid && !busy) begin
            op_q      <= csr_op;
            addr_q    <= csr_addr;
            operand_q <= csr_operand;
        end
        if (busy && grant) begin
            csr_rdata <= bus_rdata; // Old value, before this write lands
        end
    end

    always_comb begin
        case (op_q)
            core_pkg::CSR_RW: new_value = operand_q;
            core_pkg::CSR_RS: new_value = bus_rdata | operand_q;
            core_pkg::CSR_RC: new_value = bus_rdata & ~operand_q;
            default:          new_value = bus_rdata;
        endcase
    end

    // Set and clear with a zero operand are pure reads
    assign write_en = (op_q == core_pkg::CSR_RW) || (operand_q != '0);

    assign bus_req.req   = busy;
    assign bus_req.addr  = addr_q;
    assign bus_req.we    = busy && write_en;
    assign bus_req.wdata = new_value;

    assign csr_busy = busy;

    a_no_valid_while_busy: assert property (
        @(posedge clk) disable iff (reset) csr_valid |-> !busy
    );

endmodule

//--- csr_pkg.sv
package csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Machine mode registers
    parameter csr_addr_t CSR_MSTATUS  = 12'h300;
    parameter csr_addr_t CSR_MIE      = 12'h304;
    parameter csr_addr_t CSR_MTVEC    = 12'h305;
    parameter csr_addr_t CSR_MSCRATCH = 12'h340;
    parameter csr_addr_t CSR_MEPC     = 12'h341;
    parameter csr_addr_t CSR_MCAUSE   = 12'h342;
    parameter csr_addr_t CSR_MTVAL    = 12'h343;
    parameter csr_addr_t CSR_MIP      = 12'h344;
    parameter csr_addr_t CSR_MCYCLE   = 12'hB00;
    parameter csr_addr_t CSR_MHARTID  = 12'hF14;

    // Supervisor address translation, plain storage only
    parameter csr_addr_t CSR_SATP     = 12'h180;

    parameter int MSTATUS_MIE_BIT  = 3;
    parameter int MSTATUS_MPIE_BIT = 7;

    // Bits that software and the trap unit can change
    parameter core_pkg::word_t MSTATUS_MASK = 32'h0000_0088;
    parameter core_pkg::word_t MTVEC_MASK   = 32'hFFFF_FFFC; // Direct mode only
    parameter core_pkg::word_t MIP_MASK     = 32'h0000_0888; // MSIP, MTIP and MEIP

    // Access to the CSR storage, one per cycle
    typedef struct packed {
        logic            req;
        csr_addr_t       addr;
        logic            we;
        core_pkg::word_t wdata;
    } csr_bus_t;

endpackage

//--- csr_subsystem.sv
`timescale 1ns/100ps

module csr_subsystem #(
    parameter core_pkg::word_t HART_ID = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                csr_valid,
    input  core_pkg::csr_op_t   csr_op,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  core_pkg::word_t     csr_operand,
    output logic                csr_busy,
    output logic                csr_done,
    output core_pkg::word_t     csr_rdata,
    input  logic                trap_valid,
    input  core_pkg::trap_req_t trap_req,
    input  logic                mret_valid,
    output logic                trap_busy,
    output logic                redirect,
    output core_pkg::word_t     redirect_pc
);

    csr_pkg::csr_bus_t trap_bus;
    csr_pkg::csr_bus_t instr_bus;
    csr_pkg::csr_bus_t bus;
    logic              trap_grant;
    logic              instr_grant;
    core_pkg::word_t   rdata;

    csr_instr_unit csr_instr_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .csr_valid   (csr_valid),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_operand (csr_operand),
        .csr_busy    (csr_busy),
        .csr_done    (csr_done),
        .csr_rdata   (csr_rdata),
        .bus_req     (instr_bus),
        .grant       (instr_grant),
        .bus_rdata   (rdata)
    );

    trap_unit trap_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .trap_valid  (trap_valid),
        .trap_req    (trap_req),
        .mret_valid  (mret_valid),
        .trap_busy   (trap_busy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .bus_req     (trap_bus),
        .grant       (trap_grant),
        .bus_rdata   (rdata)
    );

    csr_bus_arbiter csr_bus_arbiter_inst (
        .clk         (clk),
        .reset       (reset),
        .trap_bus    (trap_bus),
        .instr_bus   (instr_bus),
        .trap_grant  (trap_grant),
        .instr_grant (instr_grant),
        .bus         (bus)
    );

    csr_file #(
        .HART_ID (HART_ID)
    ) csr_file_inst (
        .clk   (clk),
        .reset (reset),
        .bus   (bus),
        .rdata (rdata)
    );

endmodule

//--- list.f
core_pkg.sv
csr_pkg.sv
csr_file.sv
csr_instr_unit.sv
trap_unit.sv
csr_bus_arbiter.sv
csr_subsystem.sv
tb_csr_subsystem.sv

//--- tb_csr_subsystem.sv
`timescale 1ns/100ps

module tb_csr_subsystem;

    localparam logic [1:0] KIND_CSR  = 2'd0;
    localparam logic [1:0] KIND_TRAP = 2'd1;
    localparam logic [1:0] KIND_MRET = 2'd2;
    localparam logic [1:0] KIND_BOTH = 2'd3; // Instruction and trap in the same cycle

    localparam logic [1:0] CHECK_EQ      = 2'd0;
    localparam logic [1:0] CHECK_GT_LAST = 2'd1; // Above the previous csr_rdata
    localparam logic [1:0] CHECK_GE      = 2'd2;

    localparam csr_pkg::csr_addr_t UNKNOWN_ADDR = 12'h7C0;

    typedef struct packed {
        logic [1:0]          kind;
        logic [1:0]          mode;
        core_pkg::csr_op_t   op;
        csr_pkg::csr_addr_t  addr;
        core_pkg::word_t     operand;
        core_pkg::word_t     expected;
        core_pkg::trap_req_t trap;
        core_pkg::word_t     expected_pc;
    } test_t;

    logic                clk;
    logic                reset;
    logic                csr_valid;
    core_pkg::csr_op_t   csr_op;
    csr_pkg::csr_addr_t  csr_addr;
    core_pkg::word_t     csr_operand;
    logic                csr_busy;
    logic                csr_done;
    core_pkg::word_t     csr_rdata;
    logic                trap_valid;
    core_pkg::trap_req_t trap_req;
    logic                mret_valid;
    logic                trap_busy;
    logic                redirect;
    core_pkg::word_t     redirect_pc;

    test_t           tests[$];
    int              seed = 91649;
    core_pkg::word_t rnd;
    core_pkg::word_t last_rdata;
    int              cycle_count = 0;
    int              cycle_limit = 0;
    int              errors;

    csr_subsystem #(
        .HART_ID (32'd3)
    ) csr_subsystem_inst (
        .clk         (clk),
        .reset       (reset),
        .csr_valid   (csr_valid),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_operand (csr_operand),
        .csr_busy    (csr_busy),
        .csr_done    (csr_done),
        .csr_rdata   (csr_rdata),
        .trap_valid  (trap_valid),
        .trap_req    (trap_req),
        .mret_valid  (mret_valid),
        .trap_busy   (trap_busy),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT never finished a test", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_csr(input core_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                           input core_pkg::word_t operand, input core_pkg::word_t expected,
                           input logic [1:0] mode);
        test_t t;
        t          = '0;
        t.kind     = KIND_CSR;
        t.mode     = mode;
        t.op       = op;
        t.addr     = addr;
        t.operand  = operand;
        t.expected = expected;
        tests.push_back(t);
    endtask

    task automatic add_trap(input core_pkg::word_t cause, input core_pkg::word_t pc,
                            input core_pkg::word_t tval, input core_pkg::word_t expected_pc);
        test_t t;
        t             = '0;
        t.kind        = KIND_TRAP;
        t.op          = core_pkg::CSR_RW;
        t.trap.cause  = cause;
        t.trap.pc     = pc;
        t.trap.tval   = tval;
        t.expected_pc = expected_pc;
        tests.push_back(t);
    endtask

    task automatic add_mret(input core_pkg::word_t expected_pc);
        test_t t;
        t             = '0;
        t.kind        = KIND_MRET;
        t.op          = core_pkg::CSR_RW;
        t.expected_pc = expected_pc;
        tests.push_back(t);
    endtask

    // Turns the last instruction entry into one that races a trap
    task automatic add_racing_trap(input core_pkg::word_t cause, input core_pkg::word_t pc,
                                   input core_pkg::word_t tval, input core_pkg::word_t expected_pc);
        int n;
        n                     = tests.size() - 1;
        tests[n].kind         = KIND_BOTH;
        tests[n].trap.cause   = cause;
        tests[n].trap.pc      = pc;
        tests[n].trap.tval    = tval;
        tests[n].expected_pc  = expected_pc;
    endtask

    task automatic build_table();
        core_pkg::word_t scratch;
        scratch = (rnd | 32'h0000_00F0) & ~32'h0000_0F0F;
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MSTATUS, 32'hFFFF_FFFF, 32'h0, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 32'h0000_0088, CHECK_EQ);
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MTVEC, 32'hFFFF_FFFF, 32'h0, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MTVEC, 32'h0, 32'hFFFF_FFFC, CHECK_EQ);
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MIP, 32'hFFFF_FFFF, 32'h0, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MIP, 32'h0, 32'h0000_0888, CHECK_EQ);
        add_csr(core_pkg::CSR_RW, UNKNOWN_ADDR, 32'hFFFF_FFFF, 32'h0, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, UNKNOWN_ADDR, 32'h0, 32'h0, CHECK_EQ);
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MHARTID, 32'h0000_0055, 32'h3, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MHARTID, 32'h0, 32'h3, CHECK_EQ);
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, rnd, 32'h0, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 32'h0000_00F0, rnd, CHECK_EQ);
        add_csr(core_pkg::CSR_RC, csr_pkg::CSR_MSCRATCH, 32'h0000_0F0F, rnd | 32'hF0, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 32'h0, scratch, CHECK_EQ);
        add_csr(core_pkg::CSR_RC, csr_pkg::CSR_MSCRATCH, 32'h0, scratch, CHECK_EQ);
        // Leave only MIE set before the trap
        add_csr(core_pkg::CSR_RC, csr_pkg::CSR_MSTATUS, 32'h0000_00FF, 32'h0000_0088, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0000_0008, 32'h0, CHECK_EQ);
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MTVEC, 32'h0000_1003, 32'hFFFF_FFFC, CHECK_EQ);
        add_trap(32'h2, 32'h0000_0400, 32'h0BAD_0000, 32'h0000_1000);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MEPC, 32'h0, 32'h0000_0400, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0, 32'h2, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MTVAL, 32'h0, 32'h0BAD_0000, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 32'h0000_0080, CHECK_EQ);
        add_mret(32'h0000_0400);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 32'h0000_0088, CHECK_EQ);
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MSCRATCH, 32'h1234_5678, scratch, CHECK_EQ);
        add_racing_trap(32'h7, 32'h0000_0800, 32'h0, 32'h0000_1000);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 32'h0, 32'h1234_5678, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MEPC, 32'h0, 32'h0000_0800, CHECK_EQ);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 32'h0000_0080, CHECK_EQ);
        // The counter has been running since reset
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MCYCLE, 32'h0, 32'h1, CHECK_GE);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MCYCLE, 32'h0, 32'h0, CHECK_GT_LAST);
        add_csr(core_pkg::CSR_RW, csr_pkg::CSR_MCYCLE, 32'h1000_0000, 32'h0, CHECK_GT_LAST);
        add_csr(core_pkg::CSR_RS, csr_pkg::CSR_MCYCLE, 32'h0, 32'h1000_0000, CHECK_GE);
    endtask

    task automatic check_word(input int idx, input string sig, input core_pkg::word_t got,
                              input core_pkg::word_t want);
        assert (got == want) else begin
            $display("Fail test %0d: %s = %h, expected %h", idx, sig, got, want);
            errors++;
        end
    endtask

    task automatic check_rdata(input int idx, input test_t t);
        if (t.mode == CHECK_EQ) begin
            check_word(idx, "csr_rdata", csr_rdata, t.expected);
        end else if (t.mode == CHECK_GT_LAST) begin
            assert (csr_rdata > last_rdata) else begin
                $display("Fail test %0d: csr_rdata = %h, expected above %h",
                         idx, csr_rdata, last_rdata);
                errors++;
            end
        end else begin
            assert (csr_rdata >= t.expected) else begin
                $display("Fail test %0d: csr_rdata = %h, expected at least %h",
                         idx, csr_rdata, t.expected);
                errors++;
            end
        end
        last_rdata = csr_rdata;
    endtask

    task automatic run_test(input int idx, input test_t t);
        int start;
        int done_at;
        int redirect_at;
        int want_edges;
        int errors_before;
        bit want_csr;
        bit want_trap;
        errors_before = errors;
        want_csr      = (t.kind == KIND_CSR) || (t.kind == KIND_BOTH);
        want_trap     = (t.kind != KIND_CSR);
        want_edges    = (t.kind == KIND_MRET) ? 3 : 6;
        done_at       = -1;
        redirect_at   = -1;
        @(negedge clk);
        start       = cycle_count;
        csr_valid   = want_csr;
        csr_op      = t.op;
        csr_addr    = t.addr;
        csr_operand = t.operand;
        trap_valid  = (t.kind == KIND_TRAP) || (t.kind == KIND_BOTH);
        trap_req    = t.trap;
        mret_valid  = (t.kind == KIND_MRET);
        @(negedge clk);
        csr_valid  = 1'b0;
        trap_valid = 1'b0;
        mret_valid = 1'b0;
        // Each unit is busy right after its strobe edge, and no pulse has come yet
        check_word(idx, "csr_busy", csr_busy, want_csr);
        check_word(idx, "trap_busy", trap_busy, want_trap);
        check_word(idx, "csr_done", csr_done, 1'b0);
        check_word(idx, "redirect", redirect, 1'b0);
        while ((want_csr && done_at < 0) || (want_trap && redirect_at < 0)) begin
            @(negedge clk);
            if (csr_done && done_at < 0) begin
                done_at = cycle_count - start;
                check_rdata(idx, t);
            end
            if (redirect && redirect_at < 0) begin
                redirect_at = cycle_count - start;
                check_word(idx, "redirect_pc", redirect_pc, t.expected_pc);
            end
        end
        check_word(idx, "csr_busy", csr_busy, 1'b0);
        check_word(idx, "trap_busy", trap_busy, 1'b0);
        if (t.kind == KIND_CSR) begin
            assert (done_at == 2) else begin
                $display("Test %0d: csr_done came %0d edges after csr_valid instead of 2",
                         idx, done_at);
                errors++;
            end
        end else begin
            assert (redirect_at == want_edges) else begin
                $display("Test %0d: redirect came %0d edges after the strobe instead of %0d",
                         idx, redirect_at, want_edges);
                errors++;
            end
        end
        if (errors == errors_before) begin
            $display("Test %0d kind %0d addr %h ok", idx, t.kind, t.addr);
        end else begin
            $display("Test %0d kind %0d addr %h had errors", idx, t.kind, t.addr);
        end
    endtask

    initial begin
        reset       = 1'b1;
        csr_valid   = 1'b0;
        csr_op      = core_pkg::CSR_RW;
        csr_addr    = '0;
        csr_operand = '0;
        trap_valid  = 1'b0;
        trap_req    = '0;
        mret_valid  = 1'b0;
        errors      = 0;
        last_rdata  = '0;
        rnd         = $random(seed);
        build_table();
        cycle_limit = tests.size() * 20;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (tests[i]) begin
            run_test(i, tests[i]);
        end
        $display("%0d tests run, %0d checks failed", tests.size(), errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- trap_unit.sv
`timescale 1ns/100ps

module trap_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                trap_valid,
    input  core_pkg::trap_req_t trap_req,
    input  logic                mret_valid,
    output logic                trap_busy,
    output logic                redirect,
    output core_pkg::word_t     redirect_pc,
    output csr_pkg::csr_bus_t   bus_req,
    input  logic                grant,
    input  core_pkg::word_t     bus_rdata
);

    logic                busy;
    logic                is_mret;
    logic [2:0]          step;
    logic                last_step;
    core_pkg::trap_req_t req_q;
    core_pkg::word_t     status_new;

    // Entry takes steps 0 to 4, mret takes steps 0 and 1
    assign last_step = is_mret ? (step == 3'd1) : (step == 3'd4);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            is_mret  <= 1'b0;
            step     <= '0;
            redirect <= 1'b0;
        end else begin
            redirect <= busy && grant && last_step;
            if (trap_valid || mret_valid) begin
                busy    <= 1'b1;
                is_mret <= !trap_valid;
                step    <= '0;
            end else if (busy && grant) begin
                busy <= !last_step;
                step <= step + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap_valid) begin
            req_q <= trap_req;
        end
        if (busy && grant && last_step) begin
            redirect_pc <= bus_rdata; // mtvec on entry, mepc on return
        end
    end

    always_comb begin
        status_new = bus_rdata;
        if (is_mret) begin
            status_new[csr_pkg::MSTATUS_MIE_BIT]  = bus_rdata[csr_pkg::MSTATUS_MPIE_BIT];
            status_new[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
        end else begin
            status_new[csr_pkg::MSTATUS_MPIE_BIT] = bus_rdata[csr_pkg::MSTATUS_MIE_BIT];
            status_new[csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
        end
    end

    always_comb begin
        bus_req       = '0;
        bus_req.req   = busy;
        bus_req.wdata = status_new;
        if (is_mret) begin
            case (step)
                3'd0:    {bus_req.addr, bus_req.we} = {csr_pkg::CSR_MSTATUS, busy};
                default: bus_req.addr = csr_pkg::CSR_MEPC;
            endcase
        end else begin
            case (step)
                3'd0: begin
                    {bus_req.addr, bus_req.we} = {csr_pkg::CSR_MEPC, busy};
                    bus_req.wdata = req_q.pc;
                end
                3'd1: begin
                    {bus_req.addr, bus_req.we} = {csr_pkg::CSR_MCAUSE, busy};
                    bus_req.wdata = req_q.cause;
                end
                3'd2: begin
                    {bus_req.addr, bus_req.we} = {csr_pkg::CSR_MTVAL, busy};
                    bus_req.wdata = req_q.tval;
                end
                3'd3:    {bus_req.addr, bus_req.we} = {csr_pkg::CSR_MSTATUS, busy};
                default: bus_req.addr = csr_pkg::CSR_MTVEC;
            endcase
        end
    end

    assign trap_busy = busy;

    // Fixed priority means the sequence never waits, so the redirect timing holds
    a_never_stalled: assert property (
        @(posedge clk) disable iff (reset) busy |-> grant
    );

    a_no_strobe_while_busy: assert property (
        @(posedge clk) disable iff (reset) (trap_valid || mret_valid) |-> !busy
    );

endmodule
